// ==== logic/mcu_cmd_consts.svh ====
`ifndef MCU_CMD_CONSTS_SVH
`define MCU_CMD_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Command opcodes, upper nibble of the first byte in a frame
//////////////////////////////////////////////////////////////////////

`define MCU_OP_ADDR      4'h0
`define MCU_OP_ROM_MASK  4'h1
`define MCU_OP_SAVE_MASK 4'h2
`define MCU_OP_MAPPER    4'h3
`define MCU_OP_READ      4'h8
`define MCU_OP_WRITE     4'h9
`define MCU_OP_ECHO      4'hF

// Class field shared by read and write in the memory view
`define MCU_MEM_CLASS    3'h4

// Returned on every byte of an echo frame after the command
`define MCU_ECHO_BYTE    8'hA5

// Widths and SPI pin synchronizer depth
`define MCU_ADDR_W       24
`define MCU_SYNC_STAGES  2

`endif

// ==== logic/mcu_cmd_pkg.sv ====
`include "mcu_cmd_consts.svh"

package mcu_cmd_pkg;

   // Memory address, also the format of both masks
   typedef logic [`MCU_ADDR_W-1:0] addr_t;

   typedef logic [3:0] mapper_t;

   //////////////////////////////////////////////////////////////////////
   // Command byte views
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [3:0] opcode;
      logic [3:0] imm;
   } cmd_op_t;

   // Read and write share the class, skip is set for write
   typedef struct packed {
      logic [2:0] cls;
      logic       skip;
      logic [2:0] rsvd;
      logic       inc;
   } cmd_mem_t;

   typedef union packed {
      cmd_op_t  op;
      cmd_mem_t mem;
   } cmd_word_u;

   //////////////////////////////////////////////////////////////////////
   // Stage to stage records
   //////////////////////////////////////////////////////////////////////

   // Index saturates at 255 and restarts with every frame
   typedef struct packed {
      logic       strobe;
      logic [7:0] data;
      logic [7:0] index;
   } spi_byte_t;

   typedef enum logic [2:0] {
      STEP_NONE,
      STEP_ADDR,
      STEP_ROM_MASK,
      STEP_SAVE_MASK,
      STEP_MAPPER,
      STEP_READ,
      STEP_WRITE,
      STEP_ECHO
   } step_kind_e;

   typedef struct packed {
      logic       strobe;
      step_kind_e kind;
      logic [1:0] pos;
      logic [7:0] data;
      logic       inc;
      mapper_t    imm;
   } cmd_step_t;

   typedef struct packed {
      logic       rd;
      logic       wr;
      addr_t      addr;
      logic [7:0] wdata;
   } mem_req_t;

endpackage

// ==== logic/spi_byte_rx.sv ====
`timescale 1ns/1ns
`include "mcu_cmd_consts.svh"

module spi_byte_rx (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  sck,
   input  logic                  mosi,
   input  logic                  ss_n,
   output logic                  miso,
   input  logic [7:0]            resp_byte,
   output mcu_cmd_pkg::spi_byte_t rx_byte
);

   // Synchronizer chains, newest sample in bit 0
   logic [`MCU_SYNC_STAGES-1:0] sck_sync;
   logic [`MCU_SYNC_STAGES-1:0] mosi_sync;
   logic [`MCU_SYNC_STAGES-1:0] ss_sync;
   logic                        sck_prev;
   logic                        sck_s;
   logic                        mosi_s;
   logic                        ss_s;
   logic                        sck_rise;
   logic                        sck_fall;
   logic [2:0]                  bit_cnt;
   logic [6:0]                  rx_shift;
   logic [6:0]                  tx_shift;
   logic                        tx_live;
   mcu_cmd_pkg::spi_byte_t      rx_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         sck_sync  <= '0;
         mosi_sync <= '0;
         ss_sync   <= '1;
         sck_prev  <= 1'b0;
      end else begin
         sck_sync  <= {sck_sync[`MCU_SYNC_STAGES-2:0], sck};
         mosi_sync <= {mosi_sync[`MCU_SYNC_STAGES-2:0], mosi};
         ss_sync   <= {ss_sync[`MCU_SYNC_STAGES-2:0], ss_n};
         sck_prev  <= sck_s;
      end
   end

   assign sck_s    = sck_sync[`MCU_SYNC_STAGES-1];
   assign mosi_s   = mosi_sync[`MCU_SYNC_STAGES-1];
   assign ss_s     = ss_sync[`MCU_SYNC_STAGES-1];
   assign sck_rise = sck_s & ~sck_prev;
   assign sck_fall = ~sck_s & sck_prev;

   //////////////////////////////////////////////////////////////////////
   // Bit count, byte strobe and frame index
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         bit_cnt <= '0;
         tx_live <= 1'b0;
         rx_q    <= '0;
      end else if (ss_s) begin
         bit_cnt      <= '0;
         tx_live      <= 1'b0;
         rx_q.strobe  <= 1'b0;
         rx_q.index   <= '0;
      end else begin
         rx_q.strobe <= 1'b0;
         // Index moves on once the strobed byte has been seen
         if (rx_q.strobe && rx_q.index != 8'hFF)
            rx_q.index <= rx_q.index + 8'd1;
         if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
               rx_q.strobe <= 1'b1;
               rx_q.data   <= {rx_shift, mosi_s};
            end
         end
         // MSB is presented straight from resp_byte until the first fall
         if (sck_fall) begin
            if (bit_cnt == 3'd1)
               tx_live <= 1'b1;
            else if (bit_cnt == 3'd0)
               tx_live <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sck_rise)
         rx_shift <= {rx_shift[5:0], mosi_s};
      if (sck_fall) begin
         if (bit_cnt == 3'd1)
            tx_shift <= resp_byte[6:0];
         else
            tx_shift <= {tx_shift[5:0], 1'b0};
      end
   end

   assign miso    = tx_live ? tx_shift[6] : resp_byte[7];
   assign rx_byte = rx_q;

endmodule

// ==== logic/cmd_decode.sv ====
`timescale 1ns/1ns
`include "mcu_cmd_consts.svh"

module cmd_decode (
   input  logic                   clk,
   input  logic                   rst,
   input  mcu_cmd_pkg::spi_byte_t rx_byte,
   output mcu_cmd_pkg::cmd_step_t step
);

   mcu_cmd_pkg::cmd_word_u  cmd_q;
   mcu_cmd_pkg::cmd_word_u  cur;
   mcu_cmd_pkg::step_kind_e kind;
   mcu_cmd_pkg::step_kind_e kind_q;
   logic                    strobe_q;
   logic [1:0]              pos;
   logic [1:0]              pos_q;
   logic [7:0]              data_q;
   logic                    inc;
   logic                    inc_q;
   mcu_cmd_pkg::mapper_t    imm_q;
   logic                    first;
   logic                    param_ok;

   assign first    = (rx_byte.index == 8'd0);
   // Three-byte loads take bytes 1 to 3 only
   assign param_ok = !first && (rx_byte.index <= 8'd3);

   always_comb begin
      cur  = first ? mcu_cmd_pkg::cmd_word_u'(rx_byte.data) : cmd_q;
      pos  = rx_byte.index[1:0] - 2'd1;
      inc  = (cur.mem.cls == `MCU_MEM_CLASS) && cur.mem.inc;
      kind = mcu_cmd_pkg::STEP_NONE;
      case (cur.op.opcode)
         `MCU_OP_ADDR:
            if (param_ok)
               kind = mcu_cmd_pkg::STEP_ADDR;
         `MCU_OP_ROM_MASK:
            if (param_ok)
               kind = mcu_cmd_pkg::STEP_ROM_MASK;
         `MCU_OP_SAVE_MASK:
            if (param_ok)
               kind = mcu_cmd_pkg::STEP_SAVE_MASK;
         `MCU_OP_MAPPER:
            if (first)
               kind = mcu_cmd_pkg::STEP_MAPPER;
         `MCU_OP_READ:
            kind = mcu_cmd_pkg::STEP_READ;
         // Command byte itself is never written
         `MCU_OP_WRITE:
            if (!first)
               kind = mcu_cmd_pkg::STEP_WRITE;
         `MCU_OP_ECHO:
            kind = mcu_cmd_pkg::STEP_ECHO;
         default:
            kind = mcu_cmd_pkg::STEP_NONE;
      endcase
   end

   // Kind holds between strobes and drops to none once the frame is over
   always_ff @(posedge clk) begin
      if (rst) begin
         cmd_q    <= '0;
         strobe_q <= 1'b0;
         kind_q   <= mcu_cmd_pkg::STEP_NONE;
      end else begin
         strobe_q <= rx_byte.strobe;
         if (rx_byte.strobe) begin
            if (first)
               cmd_q <= rx_byte.data;
            kind_q <= kind;
         end else if (first) begin
            kind_q <= mcu_cmd_pkg::STEP_NONE;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_byte.strobe) begin
         pos_q  <= pos;
         data_q <= rx_byte.data;
         inc_q  <= inc;
         imm_q  <= cur.op.imm;
      end
   end

   assign step = '{strobe: strobe_q, kind: kind_q, pos: pos_q, data: data_q,
                   inc: inc_q, imm: imm_q};

endmodule

// ==== logic/cmd_execute.sv ====
`timescale 1ns/1ns

module cmd_execute (
   input  logic                   clk,
   input  logic                   rst,
   input  mcu_cmd_pkg::cmd_step_t step,
   output mcu_cmd_pkg::mem_req_t  mem_req,
   output mcu_cmd_pkg::addr_t     rom_mask,
   output mcu_cmd_pkg::addr_t     save_mask,
   output mcu_cmd_pkg::mapper_t   mapper
);

   mcu_cmd_pkg::addr_t   addr_q;
   mcu_cmd_pkg::addr_t   rom_q;
   mcu_cmd_pkg::addr_t   save_q;
   mcu_cmd_pkg::mapper_t mapper_q;
   logic                 rd_q;
   logic                 wr_q;
   mcu_cmd_pkg::addr_t   req_addr_q;
   logic [7:0]           wdata_q;
   logic                 mem_step;

   // MSB first, the leading byte clears the rest of the word
   function automatic mcu_cmd_pkg::addr_t load_byte(
      input mcu_cmd_pkg::addr_t cur,
      input logic [1:0]         pos,
      input logic [7:0]         b
   );
      mcu_cmd_pkg::addr_t nxt;
      case (pos)
         2'd0:    nxt = {b, 16'h0000};
         2'd1:    nxt = {cur[23:16], b, 8'h00};
         2'd2:    nxt = {cur[23:8], b};
         default: nxt = cur;
      endcase
      return nxt;
   endfunction

   assign mem_step = step.strobe &&
                     (step.kind == mcu_cmd_pkg::STEP_READ ||
                      step.kind == mcu_cmd_pkg::STEP_WRITE);

   //////////////////////////////////////////////////////////////////////
   // Configuration registers and memory strobes
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         addr_q   <= '0;
         rom_q    <= '0;
         save_q   <= '0;
         mapper_q <= '0;
         rd_q     <= 1'b0;
         wr_q     <= 1'b0;
      end else begin
         rd_q <= step.strobe && (step.kind == mcu_cmd_pkg::STEP_READ);
         wr_q <= step.strobe && (step.kind == mcu_cmd_pkg::STEP_WRITE);
         if (step.strobe) begin
            case (step.kind)
               mcu_cmd_pkg::STEP_ADDR:
                  addr_q <= load_byte(addr_q, step.pos, step.data);
               mcu_cmd_pkg::STEP_ROM_MASK:
                  rom_q <= load_byte(rom_q, step.pos, step.data);
               mcu_cmd_pkg::STEP_SAVE_MASK:
                  save_q <= load_byte(save_q, step.pos, step.data);
               mcu_cmd_pkg::STEP_MAPPER:
                  mapper_q <= step.imm;
               // Access uses the old address, increment follows
               mcu_cmd_pkg::STEP_READ,
               mcu_cmd_pkg::STEP_WRITE:
                  if (step.inc)
                     addr_q <= addr_q + mcu_cmd_pkg::addr_t'(1);
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (mem_step) begin
         req_addr_q <= addr_q;
         wdata_q    <= step.data;
      end
   end

   assign mem_req   = '{rd: rd_q, wr: wr_q, addr: req_addr_q, wdata: wdata_q};
   assign rom_mask  = rom_q;
   assign save_mask = save_q;
   assign mapper    = mapper_q;

endmodule

// ==== logic/resp_select.sv ====
`timescale 1ns/1ns
`include "mcu_cmd_consts.svh"

module resp_select (
   input  logic                   clk,
   input  logic                   rst,
   input  mcu_cmd_pkg::cmd_step_t step,
   input  logic [7:0]             mem_rdata,
   output logic [7:0]             resp_byte
);

   // Bit 0 lines up with the read strobe, bit 1 with valid read data
   logic [1:0] rd_pipe;
   logic [7:0] data_q;
   logic       frame_idle;

   assign frame_idle = !step.strobe && (step.kind == mcu_cmd_pkg::STEP_NONE);

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_pipe <= '0;
         data_q  <= '0;
      end else begin
         rd_pipe <= {rd_pipe[0], step.strobe && (step.kind == mcu_cmd_pkg::STEP_READ)};
         if (frame_idle)
            data_q <= '0;
         else if (rd_pipe[1])
            data_q <= mem_rdata;
      end
   end

   always_comb begin
      case (step.kind)
         mcu_cmd_pkg::STEP_ECHO: resp_byte = `MCU_ECHO_BYTE;
         mcu_cmd_pkg::STEP_READ: resp_byte = data_q;
         default:                resp_byte = 8'h00;
      endcase
   end

endmodule

// ==== logic/mcu_cmd_top.sv ====
`timescale 1ns/1ns

module mcu_cmd_top (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  sck,
   input  logic                  mosi,
   input  logic                  ss_n,
   output logic                  miso,
   output mcu_cmd_pkg::mem_req_t mem_req,
   input  logic [7:0]            mem_rdata,
   output mcu_cmd_pkg::addr_t    rom_mask,
   output mcu_cmd_pkg::addr_t    save_mask,
   output mcu_cmd_pkg::mapper_t  mapper
);

   mcu_cmd_pkg::spi_byte_t rx_byte;
   mcu_cmd_pkg::cmd_step_t step;
   logic [7:0]             resp_byte;

   spi_byte_rx u_spi_byte_rx (
      .clk       (clk),
      .rst       (rst),
      .sck       (sck),
      .mosi      (mosi),
      .ss_n      (ss_n),
      .miso      (miso),
      .resp_byte (resp_byte),
      .rx_byte   (rx_byte)
   );

   cmd_decode u_cmd_decode (
      .clk     (clk),
      .rst     (rst),
      .rx_byte (rx_byte),
      .step    (step)
   );

   cmd_execute u_cmd_execute (
      .clk       (clk),
      .rst       (rst),
      .step      (step),
      .mem_req   (mem_req),
      .rom_mask  (rom_mask),
      .save_mask (save_mask),
      .mapper    (mapper)
   );

   // Response path back to the SPI shifter
   resp_select u_resp_select (
      .clk       (clk),
      .rst       (rst),
      .step      (step),
      .mem_rdata (mem_rdata),
      .resp_byte (resp_byte)
   );

endmodule

// ==== tb/mcu_cmd_assert.sv ====
`timescale 1ns/1ns

module mcu_cmd_assert (
   input logic                  clk,
   input logic                  rst,
   input logic                  ss_n,
   input mcu_cmd_pkg::mem_req_t mem_req
);

   // Read back by the testbench at the end of the run
   int unsigned fail_count = 0;

   rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
      !(mem_req.rd && mem_req.wr))
      else begin
         $error("read and write strobes high in the same cycle");
         fail_count++;
      end

   // Strobes are single cycle pulses
   rd_one_cycle: assert property (@(posedge clk) disable iff (rst)
      mem_req.rd |=> !mem_req.rd)
      else begin
         $error("read strobe held longer than one cycle");
         fail_count++;
      end

   wr_one_cycle: assert property (@(posedge clk) disable iff (rst)
      mem_req.wr |=> !mem_req.wr)
      else begin
         $error("write strobe held longer than one cycle");
         fail_count++;
      end

   no_access_idle: assert property (@(posedge clk) disable iff (rst)
      (mem_req.rd || mem_req.wr) |-> !ss_n)
      else begin
         $error("memory strobe while slave select is high");
         fail_count++;
      end

endmodule

bind mcu_cmd_top mcu_cmd_assert u_mcu_cmd_assert (
   .clk     (clk),
   .rst     (rst),
   .ss_n    (ss_n),
   .mem_req (mem_req)
);

// ==== tb/tb_mcu_cmd.sv ====
`timescale 1ns/1ns

module tb_mcu_cmd;

   localparam int SCK_HALF        = 4;
   localparam int RST_CYCLES      = 16;
   localparam int CYCLES_PER_BYTE = 160;
   localparam int TIMEOUT_BASE    = 1000;

   logic                  clk = 1'b0;
   logic                  rst;
   logic                  sck;
   logic                  mosi;
   logic                  ss_n;
   logic                  miso;
   mcu_cmd_pkg::mem_req_t mem_req;
   logic [7:0]            mem_rdata = 8'h00;
   mcu_cmd_pkg::addr_t    rom_mask;
   mcu_cmd_pkg::addr_t    save_mask;
   mcu_cmd_pkg::mapper_t  mapper;

   // Memory model state
   logic [7:0]            mem [mcu_cmd_pkg::addr_t];
   logic                  rd_pend = 1'b0;
   mcu_cmd_pkg::addr_t    rd_addr;

   string                 toks [$];
   int unsigned           total_bytes = 0;
   int unsigned           cycles = 0;
   int unsigned           cycle_limit = 0;
   int                    frame_no = 0;

   mcu_cmd_top u_mcu_cmd_top (
      .clk       (clk),
      .rst       (rst),
      .sck       (sck),
      .mosi      (mosi),
      .ss_n      (ss_n),
      .miso      (miso),
      .mem_req   (mem_req),
      .mem_rdata (mem_rdata),
      .rom_mask  (rom_mask),
      .save_mask (save_mask),
      .mapper    (mapper)
   );

   initial begin
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: tests did not finish");
         $display("sim failed");
         $fatal(1);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Synchronous memory with read data one cycle after the strobe
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      if (rd_pend)
         mem_rdata <= mem[rd_addr];
      rd_pend <= mem_req.rd;
      if (mem_req.rd) begin
         // Unwritten locations hold random bytes
         if (!mem.exists(mem_req.addr))
            mem[mem_req.addr] = 8'($urandom);
         rd_addr <= mem_req.addr;
      end
      if (mem_req.wr)
         mem[mem_req.addr] = mem_req.wdata;
   end

   task automatic flag_mismatch(input string msg);
      $display("** Error at %0t ns: %s", $time, msg);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic abort_test(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_resp(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp)
         flag_mismatch($sformatf("%s miso got %h expected %h", what, got, exp));
   endtask

   task automatic check_addr(input mcu_cmd_pkg::addr_t got, input mcu_cmd_pkg::addr_t exp,
                             input string what);
      if (got !== exp)
         flag_mismatch($sformatf("%s got %h expected %h", what, got, exp));
   endtask

   task automatic check_mapper(input mcu_cmd_pkg::mapper_t got,
                               input mcu_cmd_pkg::mapper_t exp);
      if (got !== exp)
         flag_mismatch($sformatf("mapper got %h expected %h", got, exp));
   endtask

   task automatic check_mem(input mcu_cmd_pkg::addr_t a, input logic [7:0] exp);
      if (!mem.exists(a))
         abort_test($sformatf("memory address %h was never written", a));
      else if (mem[a] !== exp)
         flag_mismatch($sformatf("memory %h got %h expected %h", a, mem[a], exp));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test file tokens
   //////////////////////////////////////////////////////////////////////

   task automatic load_tests();
      int    fd;
      int    v;
      bit    after_f;
      string tok;
      string rest;
      fd = $fopen("tb/mcu_cmd_tests.txt", "r");
      if (fd == 0)
         abort_test("cannot open tb/mcu_cmd_tests.txt");
      after_f = 1'b0;
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok.substr(0, 0) == "#") begin
            void'($fgets(rest, fd));
         end else begin
            // Byte count follows each frame letter
            if (after_f && $sscanf(tok, "%d", v) == 1)
               total_bytes += v;
            after_f = (tok == "F");
            toks.push_back(tok);
         end
      end
      $fclose(fd);
   endtask

   task automatic next_tok(output string t);
      if (toks.size() == 0)
         abort_test("test file ends in the middle of a record");
      t = toks.pop_front();
   endtask

   task automatic next_num(input bit hex, output int unsigned v);
      string t;
      next_tok(t);
      if ((hex ? $sscanf(t, "%h", v) : $sscanf(t, "%d", v)) != 1)
         abort_test($sformatf("bad number %s in test file", t));
   endtask

   //////////////////////////////////////////////////////////////////////
   // SPI master in mode 0 shifting MSB first
   //////////////////////////////////////////////////////////////////////

   task automatic shift_byte(input logic [7:0] b, input int bits, output logic [7:0] got);
      int k;
      got = 8'h00;
      for (k = 7; k > 7 - bits; k--) begin
         mosi = b[k];
         repeat (SCK_HALF) @(negedge clk);
         got[k] = miso;
         sck = 1'b1;
         repeat (SCK_HALF) @(negedge clk);
         sck = 1'b0;
      end
   endtask

   task automatic run_frame();
      int unsigned n;
      int unsigned cut;
      int unsigned v;
      int          i;
      int          bits;
      string       e;
      logic [7:0]  tx [$];
      logic [7:0]  exp [$];
      bit          care [$];
      logic [7:0]  got;
      next_num(1'b0, n);
      next_num(1'b0, cut);
      for (i = 0; i < n; i++) begin
         next_num(1'b1, v);
         tx.push_back(v[7:0]);
         next_tok(e);
         care.push_back(e != "--");
         v = 0;
         if (e != "--" && $sscanf(e, "%h", v) != 1)
            abort_test($sformatf("bad response byte %s in test file", e));
         exp.push_back(v[7:0]);
      end
      repeat ($urandom_range(16, 1)) @(negedge clk);
      ss_n = 1'b0;
      repeat (SCK_HALF) @(negedge clk);
      for (i = 0; i < n; i++) begin
         // A nonzero cut sends only the leading bits of the last byte
         bits = (i == int'(n) - 1 && cut != 0) ? int'(cut) : 8;
         shift_byte(tx[i], bits, got);
         if (bits == 8 && care[i])
            check_resp(got, exp[i], $sformatf("frame %0d byte %0d", frame_no, i));
      end
      repeat (2 * SCK_HALF) @(negedge clk);
      ss_n = 1'b1;
      repeat (2 * SCK_HALF) @(negedge clk);
      frame_no++;
   endtask

   initial begin
      string       rec;
      int unsigned v;
      int unsigned a;
      void'($urandom(16));
      rst  = 1'b1;
      sck  = 1'b0;
      mosi = 1'b0;
      ss_n = 1'b1;
      load_tests();
      cycle_limit = total_bytes * CYCLES_PER_BYTE + TIMEOUT_BASE;
      repeat (RST_CYCLES) @(negedge clk);
      rst = 1'b0;
      while (toks.size() > 0) begin
         next_tok(rec);
         case (rec)
            "F": run_frame();
            "M": begin
               next_num(1'b1, v);
               check_mapper(mapper, v[3:0]);
            end
            "R": begin
               next_num(1'b1, v);
               check_addr(rom_mask, v[23:0], "rom mask");
            end
            "S": begin
               next_num(1'b1, v);
               check_addr(save_mask, v[23:0], "save mask");
            end
            "D": begin
               next_num(1'b1, a);
               next_num(1'b1, v);
               check_mem(a[23:0], v[7:0]);
            end
            default: abort_test($sformatf("unknown record %s in test file", rec));
         endcase
      end
      repeat (SCK_HALF) @(negedge clk);
      if (u_mcu_cmd_top.u_mcu_cmd_assert.fail_count == 0) begin
         $display("sim passed");
         $finish;
      end else begin
         $display("%0d assertion failures on the memory strobes",
                  u_mcu_cmd_top.u_mcu_cmd_assert.fail_count);
         $display("sim failed");
         $fatal(1);
      end
   end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/mcu_cmd_pkg.sv
logic/spi_byte_rx.sv
logic/cmd_decode.sv
logic/cmd_execute.sv
logic/resp_select.sv
logic/mcu_cmd_top.sv
tb/mcu_cmd_assert.sv
tb/tb_mcu_cmd.sv

// ==== Bender.yml ====
package:
  name: mcu_cmd

sources:
  # Package first, then the four blocks and the top level
  - include_dirs:
      - logic
    files:
      - logic/mcu_cmd_pkg.sv
      - logic/spi_byte_rx.sv
      - logic/cmd_decode.sv
      - logic/cmd_execute.sv
      - logic/resp_select.sv
      - logic/mcu_cmd_top.sv

  # Bound checker and testbench top
  - target: test
    include_dirs:
      - logic
    files:
      - tb/mcu_cmd_assert.sv
      - tb/tb_mcu_cmd.sv

// ==== tb/mcu_cmd_tests.txt ====
# F <bytes> <cut bits> then <mosi> <miso> per byte, -- for don't care, cut 0 for a full frame
# M mapper, R rom mask, S save mask, D <addr> <data> memory byte, all in hex
F 1 0 35 00
M 5
F 4 0 10 00 3F 00 FF 00 FF 00
R 3FFFFF
F 4 0 20 00 00 00 1F 00 FF 00
S 001FFF
# Address 012000, write four bytes with increment (op 9, inc bit set)
F 4 0 00 00 01 00 20 00 00 00
F 5 0 91 00 11 00 22 00 33 00 44 00
D 012000 11
D 012001 22
D 012002 33
D 012003 44
# No increment, the last byte wins
F 4 0 00 00 01 00 21 00 00 00
F 4 0 90 00 AA 00 BB 00 CC 00
D 012100 CC
# Read with increment, data shows up one byte later
F 4 0 00 00 01 00 20 00 00 00
F 6 0 81 00 00 11 00 22 00 33 00 44 00 --
F 4 0 00 00 01 00 21 00 00 00
F 3 0 80 00 00 CC 00 CC
F 4 0 F0 00 12 A5 34 A5 56 A5
# Frames cut short by slave select
F 3 3 F0 00 77 A5 FF --
F 1 0 3A 00
M A
F 1 5 35 --
M A
# Bytes past the third parameter are ignored
F 5 0 10 00 12 00 34 00 56 00 78 00
R 123456
F 4 0 00 00 01 00 20 00 01 00
F 3 0 81 00 00 22 00 33
